// File: hw/kv_defines_pkg.sv
package kv_defines_pkg;

    // every vault word is one 32 bit dword, both in the slots and in the hash block
    localparam int KV_DWORD_W = 32;

    // a slot holds at most a 384 bit key, so twelve dwords
    localparam int KV_KEY_DWORDS = 12;

    // a SHA-512 style message block is 1024 bits, which is 32 dwords
    localparam int KV_BLOCK_DWORDS = 32;

    // key length is counted in dwords and has to hold the value 12
    localparam int KV_LEN_W = 4;

    // offset into the 32 dword hash block
    localparam int KV_BLK_OFFSET_W = 5;

    // first pad word after the message carries the single leading one bit
    localparam logic [KV_DWORD_W-1:0] KV_PAD_LEAD = 32'h8000_0000;

    // in HMAC mode the inner key block is already hashed ahead of the data,
    // so its 1024 bits count toward the message length
    localparam int KV_HMAC_KEY_BITS = 1024;

endpackage

// File: hw/kv_fsm.sv
`timescale 1ns/1ps

module kv_fsm #(
    parameter int DATA_WIDTH = 384,
    parameter int PAD = 0,
    parameter int HMAC = 0,
    localparam int RD_OFFSET_W = $clog2(DATA_WIDTH / kv_defines_pkg::KV_DWORD_W),
    localparam int WR_OFFSET_W = (PAD == 1) ? kv_defines_pkg::KV_BLK_OFFSET_W : RD_OFFSET_W
) (
    input  logic                                  clk,
    input  logic                                  rst_b,
    input  logic                                  start,
    input  logic                                  last,
    input  logic                                  pcr_hash_extend,
    output logic [RD_OFFSET_W-1:0]                read_offset,
    output logic                                  write_en,
    output logic [WR_OFFSET_W-1:0]                write_offset,
    output logic                                  write_pad,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0] pad_data,
    output logic                                  ready,
    output logic                                  done
);
    import kv_defines_pkg::*;

    // number of data dwords when the whole data width is copied
    localparam int DATA_DWORDS = DATA_WIDTH / KV_DWORD_W;
    // one extra bit so the counter can reach the full block size
    localparam int CNT_W = KV_BLK_OFFSET_W + 1;
    // dword count times 32 gives the bit count
    localparam int BIT_SHIFT = $clog2(KV_DWORD_W);

    typedef enum logic [2:0] {
        ST_IDLE   = 3'b000,
        ST_COPY   = 3'b001,
        ST_PAD    = 3'b011,
        ST_ZERO   = 3'b010,
        ST_LENGTH = 3'b110,
        ST_DONE   = 3'b100
    } state_e;

    state_e state;
    state_e state_nxt;
    logic [CNT_W-1:0] offset;
    logic [CNT_W-1:0] offset_nxt;
    logic [CNT_W-1:0] num_dwords_data;
    logic [KV_DWORD_W-1:0] length_for_pad;
    logic copy_to_done;
    logic copy_to_pad;
    logic zero_to_length;
    logic offset_en;

    assign offset_nxt = offset + CNT_W'(1);

    // plain copy and PCR extend both end after the last dword of the data width
    assign copy_to_done = (state == ST_COPY) && ((PAD == 0) || pcr_hash_extend) &&
                          (offset_nxt == CNT_W'(DATA_DWORDS));

    // padded copy ends on the dword the client flags as last
    assign copy_to_pad = (state == ST_COPY) && (PAD == 1) && !pcr_hash_extend && last;

    // the final dword of the block is reserved for the length
    assign zero_to_length = (offset_nxt == CNT_W'(KV_BLOCK_DWORDS - 1));

    // message length in bits plus the HMAC key block when that mode is enabled
    always_comb begin
        length_for_pad = KV_DWORD_W'(num_dwords_data) << BIT_SHIFT;
        if (HMAC == 1) begin
            length_for_pad = length_for_pad + KV_DWORD_W'(KV_HMAC_KEY_BITS);
        end
    end

    assign ready = (state == ST_IDLE);

    always_comb begin
        state_nxt = state;
        write_en = 1'b0;
        write_pad = 1'b0;
        offset_en = 1'b0;
        pad_data = '0;
        done = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_COPY;
                end
            end
            ST_COPY: begin
                write_en = 1'b1;
                offset_en = 1'b1;
                if (copy_to_done) begin
                    state_nxt = ST_DONE;
                end else if (copy_to_pad) begin
                    state_nxt = ST_PAD;
                end
            end
            ST_PAD: begin
                // the lead word is only ever one dword long
                write_en = 1'b1;
                write_pad = 1'b1;
                offset_en = 1'b1;
                pad_data = KV_PAD_LEAD;
                state_nxt = ST_ZERO;
            end
            ST_ZERO: begin
                write_en = 1'b1;
                write_pad = 1'b1;
                offset_en = 1'b1;
                if (zero_to_length) begin
                    state_nxt = ST_LENGTH;
                end
            end
            ST_LENGTH: begin
                write_en = 1'b1;
                write_pad = 1'b1;
                offset_en = 1'b1;
                pad_data = length_for_pad;
                state_nxt = ST_DONE;
            end
            ST_DONE: begin
                done = 1'b1;
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= ST_IDLE;
            offset <= '0;
            num_dwords_data <= '0;
        end else begin
            state <= state_nxt;
            // counter goes back to zero as the last write retires
            if (state_nxt == ST_DONE) begin
                offset <= '0;
            end else if (offset_en) begin
                offset <= offset_nxt;
            end
            // count of data dwords is the offset just past the last data dword
            if (copy_to_pad) begin
                num_dwords_data <= offset_nxt;
            end
        end
    end

    // read side only moves while data is being copied
    assign read_offset = (state == ST_COPY) ? offset[RD_OFFSET_W-1:0] : '0;
    assign write_offset = offset[WR_OFFSET_W-1:0];

endmodule

// File: hw/kv_store.sv
`timescale 1ns/1ps

module kv_store #(
    parameter int NUM_SLOTS = 8,
    localparam int SLOT_W = $clog2(NUM_SLOTS),
    localparam int WORD_OFFSET_W = $clog2(kv_defines_pkg::KV_KEY_DWORDS)
) (
    input  logic                                  clk,
    input  logic                                  rst_b,
    // write port from the write client
    input  logic                                  st_we,
    input  logic [SLOT_W-1:0]                     st_wslot,
    input  logic [WORD_OFFSET_W-1:0]              st_woffset,
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0] st_wdata,
    input  logic [kv_defines_pkg::KV_LEN_W-1:0]   st_wlen,
    // read port for the read client
    input  logic [SLOT_W-1:0]                     st_rslot,
    input  logic [WORD_OFFSET_W-1:0]              st_roffset,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0] st_rdata,
    output logic [kv_defines_pkg::KV_LEN_W-1:0]   st_rlen,
    output logic                                  st_rvalid
);
    import kv_defines_pkg::*;

    // key dwords, twelve per slot
    logic [KV_DWORD_W-1:0] slot_data [NUM_SLOTS][KV_KEY_DWORDS];
    // per slot key length in dwords
    logic [KV_LEN_W-1:0] slot_len [NUM_SLOTS];
    // a slot becomes valid on its first written dword and stays valid
    logic [NUM_SLOTS-1:0] slot_valid;

    // key storage keeps its contents across reset
    always_ff @(posedge clk) begin
        if (st_we) begin
            slot_data[st_wslot][st_woffset] <= st_wdata;
        end
    end

    // length and valid flag follow every dword of a write, so the
    // whole slot update is done once the write client finishes
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            slot_valid <= '0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_len[i] <= '0;
            end
        end else if (st_we) begin
            slot_valid[st_wslot] <= 1'b1;
            slot_len[st_wslot] <= st_wlen;
        end
    end

    // read port is purely combinational, data shows up in the same cycle
    assign st_rdata = slot_data[st_rslot][st_roffset];
    assign st_rlen = slot_len[st_rslot];
    assign st_rvalid = slot_valid[st_rslot];

endmodule

// File: hw/kv_write_client.sv
`timescale 1ns/1ps

module kv_write_client #(
    parameter int NUM_SLOTS = 8,
    localparam int SLOT_W = $clog2(NUM_SLOTS),
    localparam int WORD_OFFSET_W = $clog2(kv_defines_pkg::KV_KEY_DWORDS)
) (
    input  logic                                  clk,
    input  logic                                  rst_b,
    // result register load port
    input  logic                                  res_we,
    input  logic [WORD_OFFSET_W-1:0]              res_idx,
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0] res_data,
    // copy request
    input  logic                                  wr_start,
    input  logic [SLOT_W-1:0]                     wr_slot,
    input  logic [kv_defines_pkg::KV_LEN_W-1:0]   wr_len,
    output logic                                  wr_ready,
    output logic                                  wr_done,
    // store write port
    output logic                                  st_we,
    output logic [SLOT_W-1:0]                     st_wslot,
    output logic [WORD_OFFSET_W-1:0]              st_woffset,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0] st_wdata,
    output logic [kv_defines_pkg::KV_LEN_W-1:0]   st_wlen
);
    import kv_defines_pkg::*;

    logic [KV_DWORD_W-1:0] res_q [KV_KEY_DWORDS];
    logic [SLOT_W-1:0] slot_q;
    logic [KV_LEN_W-1:0] len_q;

    // result registers, indices past the key size are dropped
    always_ff @(posedge clk) begin
        if (res_we && (res_idx < WORD_OFFSET_W'(KV_KEY_DWORDS))) begin
            res_q[res_idx] <= res_data;
        end
    end

    // slot and length are held for the whole copy
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            slot_q <= '0;
            len_q <= '0;
        end else if (wr_start && wr_ready) begin
            slot_q <= wr_slot;
            len_q <= wr_len;
        end
    end

    assign st_wslot = slot_q;
    assign st_wlen = len_q;

    // all twelve dwords are written so a shorter key clears what a longer one left behind
    assign st_wdata = (st_woffset < len_q) ? res_q[st_woffset] : '0;

    // the copy has a fixed length, so no last flag and no PCR mode
    kv_fsm #(
        .DATA_WIDTH(KV_KEY_DWORDS * KV_DWORD_W),
        .PAD(0)
    ) u_fsm (
        .clk(clk),
        .rst_b(rst_b),
        .start(wr_start),
        .last(1'b0),
        .pcr_hash_extend(1'b0),
        .read_offset(),
        .write_en(st_we),
        .write_offset(st_woffset),
        .write_pad(),
        .pad_data(),
        .ready(wr_ready),
        .done(wr_done)
    );

endmodule

// File: hw/kv_read_client.sv
`timescale 1ns/1ps

module kv_read_client #(
    parameter int NUM_SLOTS = 8,
    parameter int HMAC = 0,
    localparam int SLOT_W = $clog2(NUM_SLOTS),
    localparam int WORD_OFFSET_W = $clog2(kv_defines_pkg::KV_KEY_DWORDS)
) (
    input  logic                                   clk,
    input  logic                                   rst_b,
    // read request
    input  logic                                   rd_start,
    input  logic [SLOT_W-1:0]                      rd_slot,
    input  logic                                   rd_pcr_extend,
    // store read port
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0]  st_rdata,
    input  logic [kv_defines_pkg::KV_LEN_W-1:0]    st_rlen,
    input  logic                                   st_rvalid,
    output logic                                   rd_ready,
    output logic                                   rd_done,
    output logic                                   rd_err,
    output logic [SLOT_W-1:0]                      st_rslot,
    output logic [WORD_OFFSET_W-1:0]               st_roffset,
    // hash block stream
    output logic                                   blk_we,
    output logic [kv_defines_pkg::KV_BLK_OFFSET_W-1:0] blk_offset,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0]  blk_data,
    output logic                                   blk_pad
);
    import kv_defines_pkg::*;

    logic [SLOT_W-1:0] slot_q;
    logic pcr_q;
    logic accept;
    logic fsm_start;
    logic fsm_last;
    logic [KV_DWORD_W-1:0] fsm_pad_data;

    assign accept = rd_start && rd_ready;

    // while idle the store looks at the requested slot so validity is known at once
    assign st_rslot = rd_ready ? rd_slot : slot_q;
    assign fsm_start = accept && st_rvalid;

    // last data dword is the one just below the stored length
    assign fsm_last = (st_roffset == WORD_OFFSET_W'(st_rlen - KV_LEN_W'(1)));

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            slot_q <= '0;
            pcr_q <= 1'b0;
            rd_err <= 1'b0;
        end else begin
            if (accept) begin
                slot_q <= rd_slot;
                pcr_q <= rd_pcr_extend;
            end
            // refused request, one cycle error pulse and no stream
            rd_err <= accept && !st_rvalid;
        end
    end

    // pad words replace store data once the message part is over
    assign blk_data = blk_pad ? fsm_pad_data : st_rdata;

    kv_fsm #(
        .DATA_WIDTH(KV_KEY_DWORDS * KV_DWORD_W),
        .PAD(1),
        .HMAC(HMAC)
    ) u_fsm (
        .clk(clk),
        .rst_b(rst_b),
        .start(fsm_start),
        .last(fsm_last),
        .pcr_hash_extend(pcr_q),
        .read_offset(st_roffset),
        .write_en(blk_we),
        .write_offset(blk_offset),
        .write_pad(blk_pad),
        .pad_data(fsm_pad_data),
        .ready(rd_ready),
        .done(rd_done)
    );

endmodule

// File: hw/kv_subsys.sv
`timescale 1ns/1ps

module kv_subsys #(
    parameter int NUM_SLOTS = 8,
    parameter int HMAC = 0,
    localparam int SLOT_W = $clog2(NUM_SLOTS),
    localparam int WORD_OFFSET_W = $clog2(kv_defines_pkg::KV_KEY_DWORDS)
) (
    input  logic                                       clk,
    input  logic                                       rst_b,
    // write client side
    input  logic                                       res_we,
    input  logic [WORD_OFFSET_W-1:0]                   res_idx,
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0]      res_data,
    input  logic                                       wr_start,
    input  logic [SLOT_W-1:0]                          wr_slot,
    input  logic [kv_defines_pkg::KV_LEN_W-1:0]        wr_len,
    output logic                                       wr_ready,
    output logic                                       wr_done,
    // read client side
    input  logic                                       rd_start,
    input  logic [SLOT_W-1:0]                          rd_slot,
    input  logic                                       rd_pcr_extend,
    output logic                                       rd_ready,
    output logic                                       rd_done,
    output logic                                       rd_err,
    output logic                                       blk_we,
    output logic [kv_defines_pkg::KV_BLK_OFFSET_W-1:0] blk_offset,
    output logic [kv_defines_pkg::KV_DWORD_W-1:0]      blk_data,
    output logic                                       blk_pad
);
    import kv_defines_pkg::*;

    // write client to store
    logic st_we;
    logic [SLOT_W-1:0] st_wslot;
    logic [WORD_OFFSET_W-1:0] st_woffset;
    logic [KV_DWORD_W-1:0] st_wdata;
    logic [KV_LEN_W-1:0] st_wlen;

    // read client to and from store
    logic [SLOT_W-1:0] st_rslot;
    logic [WORD_OFFSET_W-1:0] st_roffset;
    logic [KV_DWORD_W-1:0] st_rdata;
    logic [KV_LEN_W-1:0] st_rlen;
    logic st_rvalid;

    kv_store #(.NUM_SLOTS(NUM_SLOTS)) u_store (
        .clk(clk), .rst_b(rst_b),
        .st_we(st_we), .st_wslot(st_wslot), .st_woffset(st_woffset),
        .st_wdata(st_wdata), .st_wlen(st_wlen),
        .st_rslot(st_rslot), .st_roffset(st_roffset),
        .st_rdata(st_rdata), .st_rlen(st_rlen), .st_rvalid(st_rvalid)
    );

    kv_write_client #(.NUM_SLOTS(NUM_SLOTS)) u_write_client (
        .clk(clk), .rst_b(rst_b),
        .res_we(res_we), .res_idx(res_idx), .res_data(res_data),
        .wr_start(wr_start), .wr_slot(wr_slot), .wr_len(wr_len),
        .wr_ready(wr_ready), .wr_done(wr_done),
        .st_we(st_we), .st_wslot(st_wslot), .st_woffset(st_woffset),
        .st_wdata(st_wdata), .st_wlen(st_wlen)
    );

    // HMAC only changes the length word of the padded stream
    kv_read_client #(.NUM_SLOTS(NUM_SLOTS), .HMAC(HMAC)) u_read_client (
        .clk(clk), .rst_b(rst_b),
        .rd_start(rd_start), .rd_slot(rd_slot), .rd_pcr_extend(rd_pcr_extend),
        .st_rdata(st_rdata), .st_rlen(st_rlen), .st_rvalid(st_rvalid),
        .rd_ready(rd_ready), .rd_done(rd_done), .rd_err(rd_err),
        .st_rslot(st_rslot), .st_roffset(st_roffset),
        .blk_we(blk_we), .blk_offset(blk_offset),
        .blk_data(blk_data), .blk_pad(blk_pad)
    );

endmodule

// File: bench/kv_checker.sv
`timescale 1ns/1ps

module kv_checker #(
    parameter int NUM_SLOTS = 8,
    parameter int HMAC = 0,
    localparam int SLOT_W = $clog2(NUM_SLOTS),
    localparam int WORD_OFFSET_W = $clog2(kv_defines_pkg::KV_KEY_DWORDS)
) (
    input  logic                                       clk,
    input  logic                                       rst_b,
    input  logic                                       res_we, wr_start, rd_start, rd_pcr_extend,
    input  logic [WORD_OFFSET_W-1:0]                   res_idx,
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0]      res_data,
    input  logic [SLOT_W-1:0]                          wr_slot, rd_slot,
    input  logic [kv_defines_pkg::KV_LEN_W-1:0]        wr_len,
    input  logic                                       wr_ready, wr_done, rd_ready, rd_done,
    input  logic                                       rd_err, blk_we, blk_pad,
    input  logic [kv_defines_pkg::KV_BLK_OFFSET_W-1:0] blk_offset,
    input  logic [kv_defines_pkg::KV_DWORD_W-1:0]      blk_data,
    output int                                         errors
);
    import kv_defines_pkg::*;

    // mirror of the result registers and of every slot
    logic [KV_DWORD_W-1:0] res_m [KV_KEY_DWORDS];
    logic [KV_DWORD_W-1:0] slot_m [NUM_SLOTS][KV_KEY_DWORDS];
    int len_m [NUM_SLOTS];
    bit valid_m [NUM_SLOTS];
    // expected stream of the read in flight, one entry per block offset
    logic [KV_DWORD_W-1:0] exp_data [KV_BLOCK_DWORDS];
    bit exp_pad [KV_BLOCK_DWORDS];
    int exp_n;
    int exp_idx;
    int cyc = 0;
    int wr_t0;
    int rd_t0;
    bit wr_busy;
    bit rd_busy;
    bit err_exp;
    int err_cnt = 0;

    assign errors = err_cnt;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        err_cnt++;
    endtask

    task automatic report_text(input string msg);
        $display("ERROR %s at %0t", msg, $time);
        err_cnt++;
    endtask

    // sampling on the falling edge sees inputs that the next rising edge will take
    always @(negedge clk) begin
        if (!rst_b) begin
            wr_busy = 1'b0;
            rd_busy = 1'b0;
            err_exp = 1'b0;
        end else begin
            cyc++;
            // a refused read owns exactly one cycle of rd_err
            if (rd_err !== err_exp) report_value("rd_err", 32'(rd_err), 32'(err_exp));
            err_exp = 1'b0;
            if (!wr_busy && wr_ready !== 1'b1) report_text("wr_ready is low with no write running");
            if (!rd_busy && rd_ready !== 1'b1) report_text("rd_ready is low with no read running");
            if (res_we && int'(res_idx) < KV_KEY_DWORDS) res_m[res_idx] = res_data;
            if (wr_done) begin
                if (!wr_busy) begin
                    report_text("wr_done pulsed without a running write");
                end else if (cyc - wr_t0 != KV_KEY_DWORDS + 1) begin
                    report_text($sformatf("wr_done came %0d cycles after the start, not %0d",
                                          cyc - wr_t0, KV_KEY_DWORDS + 1));
                end
                wr_busy = 1'b0;
            end
            // a write copies all twelve dwords with zeros past the key length
            if (wr_start && wr_ready) begin
                for (int i = 0; i < KV_KEY_DWORDS; i++) begin
                    slot_m[wr_slot][i] = (i < int'(wr_len)) ? res_m[i] : '0;
                end
                len_m[wr_slot] = int'(wr_len);
                valid_m[wr_slot] = 1'b1;
                wr_busy = 1'b1;
                wr_t0 = cyc;
            end
            if (blk_we) begin
                if (!rd_busy || exp_idx >= exp_n) begin
                    report_text("blk_we is high outside an expected block stream");
                end else begin
                    if (int'(blk_offset) != exp_idx) report_value("blk_offset", 32'(blk_offset), 32'(exp_idx));
                    if (blk_data !== exp_data[exp_idx]) report_value("blk_data", blk_data, exp_data[exp_idx]);
                    if (blk_pad !== exp_pad[exp_idx]) report_value("blk_pad", 32'(blk_pad), 32'(exp_pad[exp_idx]));
                    exp_idx++;
                end
            end
            if (rd_done) begin
                if (!rd_busy) begin
                    report_text("rd_done pulsed without a running read");
                end else begin
                    if (exp_idx != exp_n) report_text($sformatf("read gave %0d words, not %0d", exp_idx, exp_n));
                    if (cyc - rd_t0 != exp_n + 1) begin
                        report_text($sformatf("rd_done came %0d cycles after the start, not %0d",
                                              cyc - rd_t0, exp_n + 1));
                    end
                end
                rd_busy = 1'b0;
            end
            if (rd_start && rd_ready) begin
                if (!valid_m[rd_slot]) begin
                    err_exp = 1'b1;
                end else begin
                    // key dwords first, then the lead one bit, zeros and the bit length
                    exp_n = rd_pcr_extend ? KV_KEY_DWORDS : KV_BLOCK_DWORDS;
                    for (int i = 0; i < KV_BLOCK_DWORDS; i++) begin
                        exp_pad[i] = 1'b1;
                        exp_data[i] = '0;
                        if (i < KV_KEY_DWORDS && (rd_pcr_extend || i < len_m[rd_slot])) begin
                            exp_pad[i] = 1'b0;
                            exp_data[i] = slot_m[rd_slot][i];
                        end else if (i == len_m[rd_slot]) begin
                            exp_data[i] = KV_PAD_LEAD;
                        end else if (i == KV_BLOCK_DWORDS - 1) begin
                            exp_data[i] = KV_DWORD_W'(len_m[rd_slot] * 32 + HMAC * KV_HMAC_KEY_BITS);
                        end
                    end
                    exp_idx = 0;
                    rd_busy = 1'b1;
                    rd_t0 = cyc;
                end
            end
        end
    end

endmodule

// File: bench/tb_kv_subsys.sv
`timescale 1ns/1ps

module tb_kv_subsys;
    import kv_defines_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_SLOTS = 8;
    localparam int SLOT_W = $clog2(NUM_SLOTS);
    localparam int WORD_OFFSET_W = $clog2(KV_KEY_DWORDS);
    // operations issued by all tests together, each well under the per operation budget
    localparam int NUM_OPS = 33;
    localparam int OP_CYCLES = 40;

    logic clk;
    logic rst_b;
    logic res_we;
    logic [WORD_OFFSET_W-1:0] res_idx;
    logic [KV_DWORD_W-1:0] res_data;
    logic wr_start;
    logic [SLOT_W-1:0] wr_slot;
    logic [KV_LEN_W-1:0] wr_len;
    logic rd_start;
    logic [SLOT_W-1:0] rd_slot;
    logic rd_pcr_extend;
    logic wr_ready, wr_done, rd_ready, rd_done, rd_err, blk_we, blk_pad;
    logic [KV_BLK_OFFSET_W-1:0] blk_offset;
    logic [KV_DWORD_W-1:0] blk_data;
    int errors;
    int err_before = 0;
    int tests_run = 0;
    int tests_failed = 0;

    kv_subsys dut0 (.*);

    kv_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_OPS * OP_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog expired: an operation never reached its done or error pulse");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // all stimulus changes 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - err_before;
        if (n == 0) begin
            $display("test %0d %s: ok", tests_run + 1, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run + 1, name, n);
            tests_failed++;
        end
        tests_run++;
        err_before = errors;
    endtask

    // fresh random result, then a copy into the slot
    task automatic write_key(input int slot, input int len, input bit poke_busy);
        for (int i = 0; i < KV_KEY_DWORDS; i++) begin
            res_we = 1'b1;
            res_idx = WORD_OFFSET_W'(i);
            res_data = $urandom;
            tick();
        end
        res_we = 1'b0;
        wr_start = 1'b1;
        wr_slot = SLOT_W'(slot);
        wr_len = KV_LEN_W'(len);
        tick();
        wr_start = 1'b0;
        if (poke_busy) begin
            repeat (2) tick();
            // the copy is still running, so this request has to be dropped
            wr_start = 1'b1;
            wr_slot = SLOT_W'(slot ^ 1);
            wr_len = KV_LEN_W'(1);
            tick();
            wr_start = 1'b0;
        end
        while (!wr_done) tick();
        tick();
    endtask

    task automatic read_slot(input int slot, input bit pcr, input bit poke_busy);
        rd_start = 1'b1;
        rd_slot = SLOT_W'(slot);
        rd_pcr_extend = pcr;
        tick();
        rd_start = 1'b0;
        if (poke_busy) begin
            repeat (2) tick();
            rd_start = 1'b1;
            rd_slot = SLOT_W'(slot ^ 1);
            rd_pcr_extend = !pcr;
            tick();
            rd_start = 1'b0;
        end
        // a refused read shows rd_err right after the start edge
        while (!rd_done && !rd_err) tick();
        tick();
    endtask

    initial begin
        int slot;
        int len;
        void'($urandom(32'h516c));
        rst_b = 1'b0;
        res_we = 1'b0;
        res_idx = '0;
        res_data = '0;
        wr_start = 1'b0;
        wr_slot = '0;
        wr_len = '0;
        rd_start = 1'b0;
        rd_slot = '0;
        rd_pcr_extend = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_b = 1'b1;

        repeat (4) tick();
        end_test("idle after reset");

        // every slot is still invalid here
        read_slot($urandom_range(NUM_SLOTS - 1, 0), 1'b0, 1'b0);
        end_test("read of an empty slot");

        for (int k = 0; k < 8; k++) begin
            slot = $urandom_range(NUM_SLOTS - 1, 0);
            len = $urandom_range(KV_KEY_DWORDS, 1);
            write_key(slot, len, 1'b0);
            read_slot(slot, 1'b0, 1'b0);
        end
        end_test("write and padded read");

        for (int k = 0; k < 4; k++) begin
            slot = $urandom_range(NUM_SLOTS - 1, 0);
            write_key(slot, $urandom_range(KV_KEY_DWORDS, 1), 1'b0);
            read_slot(slot, 1'b1, 1'b0);
        end
        end_test("PCR extend read");

        slot = $urandom_range(NUM_SLOTS - 1, 0);
        write_key(slot, KV_KEY_DWORDS, 1'b0);
        write_key(slot, $urandom_range(4, 1), 1'b0);
        read_slot(slot, 1'b0, 1'b0);
        read_slot(slot, 1'b1, 1'b0);
        end_test("shorter rewrite");

        slot = $urandom_range(NUM_SLOTS - 1, 0);
        write_key(slot, $urandom_range(KV_KEY_DWORDS, 1), 1'b1);
        read_slot(slot, 1'b0, 1'b1);
        read_slot(slot, 1'b1, 1'b1);
        // the slot named by the dropped requests must look untouched
        read_slot(slot ^ 1, 1'b0, 1'b0);
        end_test("start while busy");

        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/kv_defines_pkg.sv
hw/kv_fsm.sv
hw/kv_store.sv
hw/kv_write_client.sv
hw/kv_read_client.sv
hw/kv_subsys.sv
bench/kv_checker.sv
bench/tb_kv_subsys.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_kv_subsys -o sim_kv
./obj_dir/sim_kv > sim.log 2>&1 || true
cat sim.log
if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1
